// ==== ctrl_pkg.sv ====
////////////////////////////////////////
// Shared types and constants for the control core
// Bus request, settings write and register set structs
////////////////////////////////////////

package ctrl_pkg;

   ////////////////////////////////////////
   // Widths
   localparam int DATA_W     = 32;
   localparam int ADDR_W     = 8;
   // Settings address is the low part of the bus address
   localparam int SET_ADDR_W = 6;
   localparam int RB_SEL_W   = 4;
   localparam int LED_W      = 8;

   // LED bits 1..4 follow hardware status out of reset
   localparam logic [LED_W-1:0] LED_SRC_AT_RESET = 8'h1E;

   // Readback index with no word behind it, reads zero
   localparam logic [RB_SEL_W-1:0] RB_NONE = 4'hF;

   ////////////////////////////////////////
   // Address map
   // Region from the top two bus address bits
   typedef enum logic [1:0] {
      REGION_SETTINGS = 2'b00,
      REGION_READBACK = 2'b01,
      REGION_RSVD2    = 2'b10,
      REGION_RSVD3    = 2'b11
   } bus_region_e;

   // Settings register addresses
   typedef enum logic [SET_ADDR_W-1:0] {
      SR_CLK     = 6'd0,
      SR_SER     = 6'd1,
      SR_ADC     = 6'd2,
      SR_LED_SW  = 6'd3,
      SR_PHY     = 6'd4,
      SR_LED_SRC = 6'd8
   } sr_addr_e;

   // Readback word indexes
   typedef enum logic [RB_SEL_W-1:0] {
      RB_CLK     = 4'd0,
      RB_SER     = 4'd1,
      RB_ADC     = 4'd2,
      RB_LED_SW  = 4'd3,
      RB_PHY     = 4'd4,
      RB_LED_SRC = 4'd5,
      RB_LEDS    = 4'd6,
      RB_CYCLES  = 4'd7
   } rb_word_e;

   ////////////////////////////////////////
   // Structs
   // Host request, 41 bits
   typedef struct packed {
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } bus_req_t;

   // One settings write, 39 bits
   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     data;
   } set_wr_t;

   // Register bank contents, 41 bits
   typedef struct packed {
      logic [7:0]       clk_reg;
      logic [7:0]       ser_reg;
      logic [7:0]       adc_reg;
      logic [LED_W-1:0] led_sw;
      logic             phy_reset;
      logic [LED_W-1:0] led_src;
   } ctrl_regs_t;

   // Hardware LED sources
   typedef struct packed {
      logic run_tx;
      logic run_rx;
      logic clk_status;
      logic serdes_link_up;
   } hw_status_t;

endpackage

// ==== settings_bus.sv ====
////////////////////////////////////////
// Host request slave of the control core
// Turns writes into settings strobes and reads into readback strobes
////////////////////////////////////////
`timescale 1ns/1ps

module settings_bus import ctrl_pkg::*; (
   input  logic                wb_clk,
   input  logic                wb_rst,
   // Host request port
   input  bus_req_t            req_i,
   input  logic                req_valid_i,
   output logic                req_ready_o,
   // Settings write strobe
   output set_wr_t             set_wr_o,
   // Readback request
   output logic                rb_rd_o,
   output logic [RB_SEL_W-1:0] rb_sel_o,
   input  logic                rb_done_i
);

   // One read outstanding at most
   typedef enum logic {
      ST_IDLE,
      ST_READ
   } rd_state_e;

   rd_state_e   state;
   bus_req_t    req_q;
   logic        req_vld_q;
   logic        rd_pend;
   logic        req_xfer;
   bus_region_e region;

   ////////////////////////////////////////
   // Request capture
   // Read waiting in the capture stage
   assign rd_pend     = req_vld_q & ~req_q.we;
   // Stall while a read is anywhere in flight
   assign req_ready_o = (state == ST_IDLE) & ~rd_pend;
   assign req_xfer    = req_valid_i & req_ready_o;

   always_ff @(posedge wb_clk) begin
      if (req_xfer) begin
         req_q <= req_i;
      end
      if (wb_rst) begin
         req_vld_q <= 1'b0;
      end else begin
         req_vld_q <= req_xfer;
      end
   end

   // Top address bits pick the region
   assign region = bus_region_e'(req_q.addr[ADDR_W-1 -: 2]);

   ////////////////////////////////////////
   // Settings write
   always_ff @(posedge wb_clk) begin
      set_wr_o.addr <= req_q.addr[SET_ADDR_W-1:0];
      set_wr_o.data <= req_q.data;
      // Writes outside the settings region are dropped here
      if (wb_rst) begin
         set_wr_o.stb <= 1'b0;
      end else begin
         set_wr_o.stb <= req_vld_q & req_q.we & (region == REGION_SETTINGS);
      end
   end

   ////////////////////////////////////////
   // Readback request and read FSM
   always_ff @(posedge wb_clk) begin
      // Non-readback regions land on an empty index
      if (rd_pend) begin
         rb_sel_o <= (region == REGION_READBACK) ? req_q.addr[RB_SEL_W-1:0] : RB_NONE;
      end
      if (wb_rst) begin
         rb_rd_o <= 1'b0;
         state   <= ST_IDLE;
      end else begin
         rb_rd_o <= rd_pend;
         case (state)
            ST_IDLE: if (rd_pend)   state <= ST_READ;
            ST_READ: if (rb_done_i) state <= ST_IDLE;
            default:                state <= ST_IDLE;
         endcase
      end
   end

   // Waiting on a response means no new read goes out
   a_no_rd_in_read: assert property (@(posedge wb_clk) disable iff (wb_rst)
      state == ST_READ |=> !rb_rd_o);

endmodule

// ==== setting_regs.sv ====
////////////////////////////////////////
// Settings register bank of the control core
// Drives clock, SERDES, ADC and PHY lines and picks each LED source
////////////////////////////////////////
`timescale 1ns/1ps

module setting_regs import ctrl_pkg::*; (
   input  logic             wb_clk,
   input  logic             wb_rst,
   // Settings strobe from the bus decoder
   input  set_wr_t          set_wr_i,
   // Hardware LED sources
   input  hw_status_t       hw_i,
   // Register contents for readback
   output ctrl_regs_t       regs_o,
   output logic [LED_W-1:0] leds_o,
   // Clock generator
   output logic             clock_ready_o,
   output logic [1:0]       clk_en_o,
   output logic [1:0]       clk_sel_o,
   // SERDES
   output logic             ser_enable_o,
   output logic             ser_prbsen_o,
   output logic             ser_loopen_o,
   output logic             ser_rx_en_o,
   // ADC
   output logic             adc_oe_a_o,
   output logic             adc_on_a_o,
   output logic             adc_oe_b_o,
   output logic             adc_on_b_o,
   // PHY
   output logic             phy_reset_n_o
);

   ctrl_regs_t       regs;
   logic [LED_W-1:0] led_hw;

   ////////////////////////////////////////
   // Register bank
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         // LED source comes up partly hardware driven
         regs <= '{led_src: LED_SRC_AT_RESET, default: '0};
      end else if (set_wr_i.stb) begin
         // Each register keeps the low data bits
         case (sr_addr_e'(set_wr_i.addr))
            SR_CLK:     regs.clk_reg   <= set_wr_i.data[7:0];
            SR_SER:     regs.ser_reg   <= set_wr_i.data[7:0];
            SR_ADC:     regs.adc_reg   <= set_wr_i.data[7:0];
            SR_LED_SW:  regs.led_sw    <= set_wr_i.data[LED_W-1:0];
            SR_PHY:     regs.phy_reset <= set_wr_i.data[0];
            SR_LED_SRC: regs.led_src   <= set_wr_i.data[LED_W-1:0];
            // Unused addresses change nothing
            default: ;
         endcase
      end
   end

   assign regs_o = regs;

   ////////////////////////////////////////
   // Control lines
   // Clock gen, low five bits
   assign {clock_ready_o, clk_en_o, clk_sel_o} = regs.clk_reg[4:0];

   // SERDES, low four bits
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = regs.ser_reg[3:0];

   // ADC, low four bits
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = regs.adc_reg[3:0];

   // PHY pin is active low
   assign phy_reset_n_o = ~regs.phy_reset;

   ////////////////////////////////////////
   // LEDs
   // Hardware word sits on bits 4..1
   assign led_hw = {3'b000, hw_i.run_tx, hw_i.run_rx, hw_i.clk_status,
                    hw_i.serdes_link_up, 1'b0};

   // 1 in led_src picks hardware, 0 picks software
   assign leds_o = (regs.led_src & led_hw) | (~regs.led_src & regs.led_sw);

endmodule

// ==== readback_mux.sv ====
////////////////////////////////////////
// Readback word select for the control core
// Registers one word per read strobe and holds a cycle counter
////////////////////////////////////////
`timescale 1ns/1ps

module readback_mux import ctrl_pkg::*; (
   input  logic                wb_clk,
   input  logic                wb_rst,
   // Read strobe and word index
   input  logic                rd_i,
   input  logic [RB_SEL_W-1:0] sel_i,
   // Sources
   input  ctrl_regs_t          regs_i,
   input  logic [LED_W-1:0]    leds_i,
   // Response
   output logic                rsp_valid_o,
   output logic [DATA_W-1:0]   rsp_data_o
);

   logic [DATA_W-1:0] cycle_cnt;
   logic [DATA_W-1:0] rb_word;

   // Free running cycle counter
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_cnt <= '0;
      end else begin
         cycle_cnt <= cycle_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // Word select, all zero extended
   always_comb begin
      case (rb_word_e'(sel_i))
         RB_CLK:     rb_word = DATA_W'(regs_i.clk_reg);
         RB_SER:     rb_word = DATA_W'(regs_i.ser_reg);
         RB_ADC:     rb_word = DATA_W'(regs_i.adc_reg);
         RB_LED_SW:  rb_word = DATA_W'(regs_i.led_sw);
         RB_PHY:     rb_word = DATA_W'(regs_i.phy_reset);
         RB_LED_SRC: rb_word = DATA_W'(regs_i.led_src);
         RB_LEDS:    rb_word = DATA_W'(leds_i);
         RB_CYCLES:  rb_word = cycle_cnt;
         // Indexes 8..15 read zero
         default:    rb_word = '0;
      endcase
   end

   // Response register, one cycle after the strobe
   always_ff @(posedge wb_clk) begin
      if (rd_i) begin
         rsp_data_o <= rb_word;
      end
      if (wb_rst) begin
         rsp_valid_o <= 1'b0;
      end else begin
         rsp_valid_o <= rd_i;
      end
   end

   // Single cycle response pulse
   a_rsp_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
      rsp_valid_o |=> !rsp_valid_o);

endmodule

// ==== ctrl_core.sv ====
////////////////////////////////////////
// Control and status core of the radio board
// Host request port in, board control lines and LEDs out
////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_core import ctrl_pkg::*; (
   input  logic              wb_clk,
   input  logic              wb_rst,
   // Host port
   input  bus_req_t          req_i,
   input  logic              req_valid_i,
   output logic              req_ready_o,
   output logic              rsp_valid_o,
   output logic [DATA_W-1:0] rsp_data_o,
   // Status and LEDs
   input  hw_status_t        hw_i,
   output logic [LED_W-1:0]  leds_o,
   // Clock generator
   output logic              clock_ready_o,
   output logic [1:0]        clk_en_o,
   output logic [1:0]        clk_sel_o,
   // SERDES
   output logic              ser_enable_o,
   output logic              ser_prbsen_o,
   output logic              ser_loopen_o,
   output logic              ser_rx_en_o,
   // ADC
   output logic              adc_oe_a_o,
   output logic              adc_on_a_o,
   output logic              adc_oe_b_o,
   output logic              adc_on_b_o,
   // PHY
   output logic              phy_reset_n_o
);

   set_wr_t             set_wr;
   logic                rb_rd;
   logic [RB_SEL_W-1:0] rb_sel;
   ctrl_regs_t          regs;

   ////////////////////////////////////////
   // Request decode
   settings_bus u_settings_bus (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .req_i       (req_i),
      .req_valid_i (req_valid_i),
      .req_ready_o (req_ready_o),
      .set_wr_o    (set_wr),
      .rb_rd_o     (rb_rd),
      .rb_sel_o    (rb_sel),
      // Response frees the read slot
      .rb_done_i   (rsp_valid_o)
   );

   // Register bank
   setting_regs u_setting_regs (
      .wb_clk        (wb_clk),
      .wb_rst        (wb_rst),
      .set_wr_i      (set_wr),
      .hw_i          (hw_i),
      .regs_o        (regs),
      .leds_o        (leds_o),
      .clock_ready_o (clock_ready_o),
      .clk_en_o      (clk_en_o),
      .clk_sel_o     (clk_sel_o),
      .ser_enable_o  (ser_enable_o),
      .ser_prbsen_o  (ser_prbsen_o),
      .ser_loopen_o  (ser_loopen_o),
      .ser_rx_en_o   (ser_rx_en_o),
      .adc_oe_a_o    (adc_oe_a_o),
      .adc_on_a_o    (adc_on_a_o),
      .adc_oe_b_o    (adc_oe_b_o),
      .adc_on_b_o    (adc_on_b_o),
      .phy_reset_n_o (phy_reset_n_o)
   );

   // Readback
   readback_mux u_readback_mux (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .rd_i        (rb_rd),
      .sel_i       (rb_sel),
      .regs_i      (regs),
      .leds_i      (leds_o),
      .rsp_valid_o (rsp_valid_o),
      .rsp_data_o  (rsp_data_o)
   );

   // Read transfer to response is a fixed two cycle path
   a_rd_latency: assert property (@(posedge wb_clk) disable iff (wb_rst)
      req_valid_i && req_ready_o && !req_i.we |-> ##3 rsp_valid_o);

endmodule

// ==== tb_ctrl_core.sv ====
////////////////////////////////////////
// Directed testbench for the control core
// Drives host requests, checks control lines, LEDs and readback words
////////////////////////////////////////
`timescale 1ns/1ps

module tb_ctrl_core import ctrl_pkg::*; ();

   // Tests run about 600 cycles so stop well past that
   localparam int TIMEOUT_CYCLES = 2000;
   localparam logic [31:0] SEED = 32'h3117;

   // Unused settings addresses, the readback region and the reserved regions
   localparam logic [ADDR_W-1:0] IGNORED_ADDR [8] = '{
      8'h05, 8'h07, 8'h09, 8'h3F, 8'h40, 8'h43, 8'h84, 8'hC8};
   localparam sr_addr_e BURST_ADDR [8] = '{
      SR_CLK, SR_SER, SR_ADC, SR_LED_SW, SR_PHY, SR_CLK, SR_SER, SR_LED_SRC};

   logic              wb_clk;
   logic              wb_rst;
   bus_req_t          req_i;
   logic              req_valid_i;
   logic              req_ready_o;
   logic              rsp_valid_o;
   logic [DATA_W-1:0] rsp_data_o;
   hw_status_t        hw_i;
   logic [LED_W-1:0]  leds_o;
   logic              clock_ready_o;
   logic [1:0]        clk_en_o;
   logic [1:0]        clk_sel_o;
   logic              ser_enable_o;
   logic              ser_prbsen_o;
   logic              ser_loopen_o;
   logic              ser_rx_en_o;
   logic              adc_oe_a_o;
   logic              adc_on_a_o;
   logic              adc_oe_b_o;
   logic              adc_on_b_o;
   logic              phy_reset_n_o;

   int          cyc = 0;
   int          errors = 0;
   int          test_err = 0;
   int          pass_cnt = 0;
   int          fail_cnt = 0;
   // Cycle of the latest write transfer
   int          wr_t = 0;
   logic [31:0] rnd;
   // Expected register contents
   ctrl_regs_t  model;

   ctrl_core UUT (.*);

   initial begin
      wb_clk = 1'b0;
      forever #4 wb_clk = ~wb_clk;
   end

   // Cycle count for latency checks and the run limit
   always @(posedge wb_clk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYCLES) begin
         $display("Run stopped after %0d cycles, a test never finished", cyc);
         $display("TEST FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Reference model and compares
   function automatic logic [LED_W-1:0] led_expect(input logic [LED_W-1:0] src,
                                                  input logic [LED_W-1:0] sw,
                                                  input hw_status_t hw);
      logic [LED_W-1:0] hw_word;
      logic [LED_W-1:0] res;
      hw_word    = '0;
      hw_word[4] = hw.run_tx;
      hw_word[3] = hw.run_rx;
      hw_word[2] = hw.clk_status;
      hw_word[1] = hw.serdes_link_up;
      for (int i = 0; i < LED_W; i++) begin
         res[i] = src[i] ? hw_word[i] : sw[i];
      end
      return res;
   endfunction

   task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      // Only the settings region reaches the registers
      if (addr[7:6] == REGION_SETTINGS) begin
         case (addr[5:0])
            SR_CLK:     model.clk_reg   = data[7:0];
            SR_SER:     model.ser_reg   = data[7:0];
            SR_ADC:     model.adc_reg   = data[7:0];
            SR_LED_SW:  model.led_sw    = data[7:0];
            SR_PHY:     model.phy_reset = data[0];
            SR_LED_SRC: model.led_src   = data[7:0];
            default: ;
         endcase
      end
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_leds(input string name, input logic [LED_W-1:0] exp,
                             input logic [LED_W-1:0] act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_regs(input ctrl_regs_t exp, input ctrl_regs_t act);
      if (act !== exp) begin
         $display("MISMATCH regs expected %h actual %h", exp, act);
         errors++;
      end
   endtask

   ////////////////////////////////////////
   // Host bus tasks
   // Returns just after the transfer edge with valid still high
   task automatic bus_xfer(input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, output int t_req);
      @(negedge wb_clk);
      req_i       = '{we: we, addr: addr, data: data};
      req_valid_i = 1'b1;
      while (!req_ready_o) @(negedge wb_clk);
      t_req = cyc;
      @(posedge wb_clk);
   endtask

   task automatic bus_release;
      @(negedge wb_clk);
      req_valid_i = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge wb_clk);
   endtask

   // Write takes two cycles to reach the outputs
   task automatic settle;
      bus_release();
      idle(2);
   endtask

   task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      bus_xfer(1'b1, addr, data, wr_t);
      model_write(addr, data);
   endtask

   task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output int t_req);
      bus_xfer(1'b0, addr, '0, t_req);
      bus_release();
      while (!rsp_valid_o && (cyc - t_req) < 8) @(negedge wb_clk);
      if (!rsp_valid_o) begin
         $display("No read response for address %h", addr);
         errors++;
         data = '0;
      end else begin
         data = rsp_data_o;
         // Transfer edge is one past t_req
         check_data("rsp latency", 2, cyc - t_req - 1);
         // Port stays blocked while the read is in flight
         check_data("req_ready_o", 0, DATA_W'(req_ready_o));
      end
   endtask

   task automatic read_word(input logic [RB_SEL_W-1:0] idx, output logic [DATA_W-1:0] d);
      int t;
      bus_read({REGION_READBACK, 2'b00, idx}, d, t);
   endtask

   task automatic read_regs(output ctrl_regs_t r);
      logic [DATA_W-1:0] d;
      logic [DATA_W-1:0] hi;
      hi = '0;
      read_word(RB_CLK, d);
      r.clk_reg = d[7:0];
      hi = hi | (d & ~32'hFF);
      read_word(RB_SER, d);
      r.ser_reg = d[7:0];
      hi = hi | (d & ~32'hFF);
      read_word(RB_ADC, d);
      r.adc_reg = d[7:0];
      hi = hi | (d & ~32'hFF);
      read_word(RB_LED_SW, d);
      r.led_sw = d[7:0];
      hi = hi | (d & ~32'hFF);
      read_word(RB_PHY, d);
      r.phy_reset = d[0];
      hi = hi | (d & ~32'h1);
      read_word(RB_LED_SRC, d);
      r.led_src = d[7:0];
      hi = hi | (d & ~32'hFF);
      // Words are zero extended
      check_data("readback upper bits", '0, hi);
   endtask

   task automatic start_test;
      test_err = errors;
   endtask

   task automatic finish_test(input string name);
      if (errors == test_err) begin
         pass_cnt++;
         $display("%s: pass", name);
      end else begin
         fail_cnt++;
         $display("%s: fail, %0d errors", name, errors - test_err);
      end
   endtask

   ////////////////////////////////////////
   // Tests
   task automatic test_reset;
      ctrl_regs_t r;
      start_test();
      check_data("req_ready_o", 1, DATA_W'(req_ready_o));
      read_regs(r);
      check_regs(model, r);
      check_data("phy_reset_n_o", 1, DATA_W'(phy_reset_n_o));
      check_data("control lines", 0, DATA_W'({clock_ready_o, clk_en_o, clk_sel_o,
         ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o,
         adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}));
      rnd = $urandom();
      @(negedge wb_clk);
      hw_i = hw_status_t'(rnd[3:0]);
      @(negedge wb_clk);
      check_leds("leds_o", led_expect(LED_SRC_AT_RESET, '0, hw_i), leds_o);
      finish_test("reset values");
   endtask

   task automatic test_control;
      logic [DATA_W-1:0] v;
      ctrl_regs_t        r;
      start_test();
      v = $urandom();
      bus_write({2'b00, SR_CLK}, v);
      settle();
      check_data("clk lines", DATA_W'(v[4:0]), DATA_W'({clock_ready_o, clk_en_o, clk_sel_o}));
      v = $urandom();
      bus_write({2'b00, SR_SER}, v);
      settle();
      check_data("ser lines", DATA_W'(v[3:0]),
         DATA_W'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}));
      v = $urandom();
      bus_write({2'b00, SR_ADC}, v);
      settle();
      check_data("adc lines", DATA_W'(v[3:0]),
         DATA_W'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}));
      v = $urandom();
      bus_write({2'b00, SR_PHY}, v);
      settle();
      check_data("phy_reset_n_o", DATA_W'(!v[0]), DATA_W'(phy_reset_n_o));
      read_regs(r);
      check_regs(model, r);
      finish_test("control writes");
   endtask

   task automatic test_leds;
      logic [LED_W-1:0]  exp;
      logic [DATA_W-1:0] d;
      start_test();
      repeat (4) begin
         rnd = $urandom();
         bus_write({2'b00, SR_LED_SW}, rnd);
         rnd = $urandom();
         bus_write({2'b00, SR_LED_SRC}, rnd);
         bus_release();
         rnd = $urandom();
         hw_i = hw_status_t'(rnd[3:0]);
         idle(2);
         exp = led_expect(model.led_src, model.led_sw, hw_i);
         check_leds("leds_o", exp, leds_o);
         read_word(RB_LEDS, d);
         check_data("RB_LEDS", DATA_W'(exp), d);
      end
      finish_test("led selection");
   endtask

   task automatic test_ignored;
      ctrl_regs_t        r;
      logic [DATA_W-1:0] d;
      int                t;
      start_test();
      for (int i = 0; i < 8; i++) begin
         bus_write(IGNORED_ADDR[i], $urandom());
      end
      settle();
      read_regs(r);
      check_regs(model, r);
      // Settings region and reserved region reads
      bus_read(8'h00, d, t);
      check_data("settings read 00", '0, d);
      bus_read(8'h08, d, t);
      check_data("settings read 08", '0, d);
      bus_read(8'h85, d, t);
      check_data("reserved read 85", '0, d);
      for (int i = 8; i < 16; i++) begin
         read_word(4'(i), d);
         check_data("unused readback index", '0, d);
      end
      finish_test("ignored accesses");
   endtask

   task automatic test_back_to_back;
      ctrl_regs_t r;
      int         t_first;
      start_test();
      t_first = 0;
      for (int i = 0; i < 8; i++) begin
         rnd = $urandom();
         bus_write({2'b00, BURST_ADDR[i]}, rnd);
         if (i == 0) begin
            t_first = wr_t;
         end
      end
      // Writes go out on consecutive edges
      check_data("write spacing", 7, wr_t - t_first);
      // First read transfers on the edge after the last write
      read_regs(r);
      check_regs(model, r);
      finish_test("back to back");
   endtask

   task automatic test_cycles;
      logic [DATA_W-1:0] c0;
      logic [DATA_W-1:0] c1;
      int                t0;
      int                t1;
      int                k;
      start_test();
      bus_read({REGION_READBACK, 2'b00, RB_CYCLES}, c0, t0);
      rnd = $urandom();
      k = 5 + int'(rnd[3:0]);
      idle(k);
      bus_read({REGION_READBACK, 2'b00, RB_CYCLES}, c1, t1);
      // Read handshake adds four cycles to the idle gap
      check_data("cycle delta", DATA_W'(k + 4), c1 - c0);
      finish_test("cycle counter");
   endtask

   ////////////////////////////////////////
   // Main sequence
   initial begin
      rnd         = $urandom(SEED);
      wb_rst      = 1'b1;
      req_i       = '0;
      req_valid_i = 1'b0;
      hw_i        = '0;
      model       = '{led_src: LED_SRC_AT_RESET, default: '0};
      repeat (3) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;
      test_reset();
      test_control();
      test_leds();
      test_ignored();
      test_back_to_back();
      test_cycles();
      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== src.f ====
ctrl_pkg.sv
settings_bus.sv
setting_regs.sv
readback_mux.sv
ctrl_core.sv
tb_ctrl_core.sv

// ==== Makefile ====
# Verilator build and run of the control core testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f src.f --top-module tb_ctrl_core -o sim_ctrl_core
	@out="$$(./obj_dir/sim_ctrl_core)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module ctrl_core

clean:
	rm -rf obj_dir
